// File: Makefile
TOP = tb_pcie_dma

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: source/bar_mem.sv
//**********************************************************
// BAR register memory, byte-enabled write port and one
// registered read port, cleared to zero by reset
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module bar_mem #(
    parameter int ADDR_WIDTH = dma_mem_pkg::DEF_ADDR_WIDTH
)(
    input  wire                                clk,
    input  wire                                i_rst_n,
    input  wire                                i_wr_en,
    input  wire [ADDR_WIDTH-1:0]               i_wr_addr,
    input  wire [dma_mem_pkg::MEM_WORD_W-1:0]  i_wr_data,
    input  wire [dma_mem_pkg::MEM_BE_W-1:0]    i_wr_be,
    input  wire                                i_rd_en,
    input  wire [ADDR_WIDTH-1:0]               i_rd_addr,
    output logic [dma_mem_pkg::MEM_WORD_W-1:0] o_rd_data
);

    import dma_mem_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [MEM_WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end
        else if (i_wr_en)
        begin
            // merge enabled bytes only
            for (int b = 0; b < MEM_BE_W; b++)
                if (i_wr_be[b])
                    mem[i_wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rd_en)
            o_rd_data <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

// File: source/cpl_req_fifo.sv
//**********************************************************
// Queue of pending read requests between the parser and
// the CplD builder; push and pop may share a cycle
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module cpl_req_fifo #(
    parameter int CPL_DEPTH = dma_mem_pkg::DEF_CPL_DEPTH
)(
    input  wire                               clk,
    input  wire                               i_rst_n,
    input  wire                               i_push,
    input  wire [dma_mem_pkg::CPL_REQ_W-1:0]  i_push_data,
    input  wire                               i_pop,
    output logic [dma_mem_pkg::CPL_REQ_W-1:0] o_pop_data,
    output logic                              o_empty,
    output logic                              o_full
);

    import dma_mem_pkg::*;

    localparam int PTR_W = (CPL_DEPTH > 1) ? $clog2(CPL_DEPTH) : 1;

    logic [CPL_REQ_W-1:0] buf_q [CPL_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;
    logic                 push_ok;
    logic                 pop_ok;

    assign o_empty    = (count == '0);
    assign o_full     = (count == (PTR_W+1)'(CPL_DEPTH));
    assign push_ok    = i_push && !o_full;
    assign pop_ok     = i_pop && !o_empty;
    assign o_pop_data = buf_q[rd_ptr];

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= (wr_ptr == PTR_W'(CPL_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == PTR_W'(CPL_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            // occupancy holds when both happen
            if (push_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !push_ok)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_ok)
            buf_q[wr_ptr] <= i_push_data;
    end

endmodule

`default_nettype wire

// File: source/cpl_tx_builder.sv
//**********************************************************
// CplD builder: pops a read request, fetches the BAR word
// and holds one completion beat until the link takes it
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module cpl_tx_builder #(
    parameter int ADDR_WIDTH = dma_mem_pkg::DEF_ADDR_WIDTH
)(
    input  wire                                 clk,
    input  wire                                 i_rst_n,
    input  wire [7:0]                           i_cfg_pbus_num,
    input  wire [4:0]                           i_cfg_pbus_dev_num,
    input  wire                                 i_fifo_empty,
    output logic                                o_fifo_pop,
    input  wire [dma_mem_pkg::CPL_REQ_W-1:0]    i_req_data,
    output logic                                o_mem_rd_en,
    output logic [ADDR_WIDTH-1:0]               o_mem_rd_addr,
    input  wire [dma_mem_pkg::MEM_WORD_W-1:0]   i_mem_rd_data,
    output logic                                o_cpl_busy,
    output logic                                o_axis_slave_tvld,
    input  wire                                 i_axis_slave_trdy,
    output logic [pcie_tlp_pkg::TLP_DATA_W-1:0] o_axis_slave_tdata,
    output logic                                o_axis_slave_tlast
);

    import pcie_tlp_pkg::*;
    import dma_mem_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_READ = 2'd1;
    localparam logic [1:0] ST_SEND = 2'd2;

    logic [1:0]           state;
    logic [CPL_REQ_W-1:0] req_q;
    logic [2:0]           rq_tc;
    logic [1:0]           rq_attr;
    logic [15:0]          rq_id;
    logic [7:0]           rq_tag;
    logic [CPL_LO_W-1:0]  rq_lo;
    logic [CPL_IDX_W-1:0] rq_idx;
    tlp_hdr_u             beat;

    assign {rq_tc, rq_attr, rq_id, rq_tag, rq_lo, rq_idx} = req_q;

    assign o_fifo_pop         = (state == ST_IDLE) && !i_fifo_empty;
    assign o_mem_rd_en        = (state == ST_READ);
    assign o_mem_rd_addr      = rq_idx[ADDR_WIDTH-1:0];
    assign o_cpl_busy         = (state != ST_IDLE);
    assign o_axis_slave_tvld  = (state == ST_SEND);
    assign o_axis_slave_tlast = 1'b1;
    assign o_axis_slave_tdata = beat;

    //**********************************************************
    // idle -> read -> send, back to idle on transfer
    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            state <= ST_IDLE;
        else
        begin
            case (state)
                ST_IDLE: if (!i_fifo_empty) state <= ST_READ;
                ST_READ: state <= ST_SEND;
                ST_SEND: if (i_axis_slave_trdy) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_fifo_pop)
            req_q <= i_req_data;
    end

    //**********************************************************
    // completion header, memory word rides in DW3
    always_comb
    begin
        beat                = '0;
        beat.cpl.fmt_type   = FMT_TYPE_CPLD;
        beat.cpl.tc         = rq_tc;
        beat.cpl.attr       = rq_attr;
        beat.cpl.length     = TLP_LEN_W'(1);
        beat.cpl.cpl_id     = {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000};
        beat.cpl.status     = CPL_STATUS_SC;
        beat.cpl.byte_cnt   = TLP_BCNT_W'(4);
        beat.cpl.req_id     = rq_id;
        beat.cpl.tag        = rq_tag;
        beat.cpl.lower_addr = {rq_lo, 2'b00};
        beat.cpl.data       = i_mem_rd_data;
    end

endmodule

`default_nettype wire

// File: source/dma_mem_pkg.sv
//**********************************************************
// BAR memory geometry and the packed read request word
// passed from the parser through the completion queue
//**********************************************************
`default_nettype none

package dma_mem_pkg;

    localparam int MEM_WORD_W     = 32;
    localparam int MEM_BE_W       = 4;
    localparam int DEF_ADDR_WIDTH = 6;
    localparam int DEF_CPL_DEPTH  = 4;

    // read request, msb first:
    // tc, attr, requester id, tag, addr[6:2], word index
    localparam int CPL_LO_W  = 5;
    // word index field, holds any ADDR_WIDTH up to 12
    localparam int CPL_IDX_W = 12;
    localparam int CPL_REQ_W = 3 + 2 + 16 + 8 + CPL_LO_W + CPL_IDX_W;

endpackage

`default_nettype wire

// File: source/pcie_dma_top.sv
//**********************************************************
// PCIe DMA endpoint target: BAR writes from inbound MWR,
// CplD answers to inbound MRD on the slave stream
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module pcie_dma_top #(
    parameter int ADDR_WIDTH = dma_mem_pkg::DEF_ADDR_WIDTH,
    parameter int CPL_DEPTH  = dma_mem_pkg::DEF_CPL_DEPTH
)(
    input  wire                                 clk,
    input  wire                                 i_rst_n,
    input  wire [7:0]                           i_cfg_pbus_num,
    input  wire [4:0]                           i_cfg_pbus_dev_num,
    // inbound stream
    input  wire                                 i_axis_master_tvld,
    output logic                                o_axis_master_trdy,
    input  wire [pcie_tlp_pkg::TLP_DATA_W-1:0]  i_axis_master_tdata,
    input  wire [3:0]                           i_axis_master_tkeep,
    input  wire                                 i_axis_master_tlast,
    // outbound completions
    input  wire                                 i_axis_slave_trdy,
    output logic                                o_axis_slave_tvld,
    output logic [pcie_tlp_pkg::TLP_DATA_W-1:0] o_axis_slave_tdata,
    output logic                                o_axis_slave_tlast
);

    import dma_mem_pkg::*;

    logic                   mem_wr_en;
    logic [ADDR_WIDTH-1:0]  mem_wr_addr;
    logic [MEM_WORD_W-1:0]  mem_wr_data;
    logic [MEM_BE_W-1:0]    mem_wr_be;
    logic                   mem_rd_en;
    logic [ADDR_WIDTH-1:0]  mem_rd_addr;
    logic [MEM_WORD_W-1:0]  mem_rd_data;
    logic                   req_push;
    logic [CPL_REQ_W-1:0]   req_push_data;
    logic                   req_pop;
    logic [CPL_REQ_W-1:0]   req_pop_data;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   cpl_busy;

    tlp_rx_parser #(
        .ADDR_WIDTH         (ADDR_WIDTH)
    ) u_tlp_rx_parser (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_axis_master_tvld (i_axis_master_tvld),
        .o_axis_master_trdy (o_axis_master_trdy),
        .i_axis_master_tdata(i_axis_master_tdata),
        .i_axis_master_tlast(i_axis_master_tlast),
        .i_fifo_full        (fifo_full),
        .i_fifo_empty       (fifo_empty),
        .i_cpl_busy         (cpl_busy),
        .o_mem_wr_en        (mem_wr_en),
        .o_mem_wr_addr      (mem_wr_addr),
        .o_mem_wr_data      (mem_wr_data),
        .o_mem_wr_be        (mem_wr_be),
        .o_req_push         (req_push),
        .o_req_data         (req_push_data)
    );

    bar_mem #(
        .ADDR_WIDTH         (ADDR_WIDTH)
    ) u_bar_mem (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_wr_en            (mem_wr_en),
        .i_wr_addr          (mem_wr_addr),
        .i_wr_data          (mem_wr_data),
        .i_wr_be            (mem_wr_be),
        .i_rd_en            (mem_rd_en),
        .i_rd_addr          (mem_rd_addr),
        .o_rd_data          (mem_rd_data)
    );

    cpl_req_fifo #(
        .CPL_DEPTH          (CPL_DEPTH)
    ) u_cpl_req_fifo (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_push             (req_push),
        .i_push_data        (req_push_data),
        .i_pop              (req_pop),
        .o_pop_data         (req_pop_data),
        .o_empty            (fifo_empty),
        .o_full             (fifo_full)
    );

    cpl_tx_builder #(
        .ADDR_WIDTH         (ADDR_WIDTH)
    ) u_cpl_tx_builder (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_cfg_pbus_num     (i_cfg_pbus_num),
        .i_cfg_pbus_dev_num (i_cfg_pbus_dev_num),
        .i_fifo_empty       (fifo_empty),
        .o_fifo_pop         (req_pop),
        .i_req_data         (req_pop_data),
        .o_mem_rd_en        (mem_rd_en),
        .o_mem_rd_addr      (mem_rd_addr),
        .i_mem_rd_data      (mem_rd_data),
        .o_cpl_busy         (cpl_busy),
        .o_axis_slave_tvld  (o_axis_slave_tvld),
        .i_axis_slave_trdy  (i_axis_slave_trdy),
        .o_axis_slave_tdata (o_axis_slave_tdata),
        .o_axis_slave_tlast (o_axis_slave_tlast)
    );

endmodule

`default_nettype wire

// File: source/pcie_tlp_pkg.sv
//**********************************************************
// TLP header layouts and fmt/type codes for the 128-bit
// AXI-stream beat, shared by the parser and CplD builder
//**********************************************************
`default_nettype none

package pcie_tlp_pkg;

    localparam int TLP_DATA_W  = 128;
    localparam int TLP_LEN_W   = 10;
    localparam int TLP_BCNT_W  = 12;
    localparam int TLP_LADDR_W = 7;

    // fmt/type, 3DW headers only
    localparam logic [7:0] FMT_TYPE_MRD32 = 8'h00;
    localparam logic [7:0] FMT_TYPE_MWR32 = 8'h40;
    localparam logic [7:0] FMT_TYPE_CPLD  = 8'h4a;

    localparam logic [2:0] CPL_STATUS_SC  = 3'b000;

    // request view, DW0 sits in bits 31:0
    typedef struct packed {
        logic [31:0]            data;
        logic [29:0]            addr;
        logic [1:0]             addr_rsvd;
        logic [15:0]            req_id;
        logic [7:0]             tag;
        logic [3:0]             last_be;
        logic [3:0]             first_be;
        logic [7:0]             fmt_type;
        logic                   rsvd0;
        logic [2:0]             tc;
        logic [3:0]             rsvd1;
        logic                   td;
        logic                   ep;
        logic [1:0]             attr;
        logic [1:0]             at;
        logic [TLP_LEN_W-1:0]   length;
    } req_hdr_t;

    // completion view, same DW0 layout
    typedef struct packed {
        logic [31:0]            data;
        logic [15:0]            req_id;
        logic [7:0]             tag;
        logic                   rsvd2;
        logic [TLP_LADDR_W-1:0] lower_addr;
        logic [15:0]            cpl_id;
        logic [2:0]             status;
        logic                   bcm;
        logic [TLP_BCNT_W-1:0]  byte_cnt;
        logic [7:0]             fmt_type;
        logic                   rsvd0;
        logic [2:0]             tc;
        logic [3:0]             rsvd1;
        logic                   td;
        logic                   ep;
        logic [1:0]             attr;
        logic [1:0]             at;
        logic [TLP_LEN_W-1:0]   length;
    } cpl_hdr_t;

    typedef union packed {
        req_hdr_t req;
        cpl_hdr_t cpl;
    } tlp_hdr_u;

endpackage

`default_nettype wire

// File: source/tlp_rx_parser.sv
//**********************************************************
// Inbound TLP parser: single-beat MWR goes to BAR memory,
// MRD is queued for completion, everything else dropped
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module tlp_rx_parser #(
    parameter int ADDR_WIDTH = dma_mem_pkg::DEF_ADDR_WIDTH
)(
    input  wire                                clk,
    input  wire                                i_rst_n,
    input  wire                                i_axis_master_tvld,
    output logic                               o_axis_master_trdy,
    input  wire [pcie_tlp_pkg::TLP_DATA_W-1:0] i_axis_master_tdata,
    input  wire                                i_axis_master_tlast,
    input  wire                                i_fifo_full,
    input  wire                                i_fifo_empty,
    input  wire                                i_cpl_busy,
    output logic                               o_mem_wr_en,
    output logic [ADDR_WIDTH-1:0]              o_mem_wr_addr,
    output logic [dma_mem_pkg::MEM_WORD_W-1:0] o_mem_wr_data,
    output logic [dma_mem_pkg::MEM_BE_W-1:0]   o_mem_wr_be,
    output logic                               o_req_push,
    output logic [dma_mem_pkg::CPL_REQ_W-1:0]  o_req_data
);

    import pcie_tlp_pkg::*;
    import dma_mem_pkg::*;

    tlp_hdr_u   hdr;
    logic       rx_en;
    logic       discard_q;
    logic       beat_ok;
    logic       is_mwr;
    logic       is_mrd;
    logic       accept;

    assign hdr = i_axis_master_tdata;

    // first beat must also be the last, with one DW of payload
    assign beat_ok = !discard_q && i_axis_master_tlast
                     && (hdr.req.length == TLP_LEN_W'(1));
    assign is_mwr  = (hdr.req.fmt_type == FMT_TYPE_MWR32);
    assign is_mrd  = (hdr.req.fmt_type == FMT_TYPE_MRD32);

    // a new MWR waits until every queued read has left memory
    always_comb
    begin
        o_axis_master_trdy = rx_en && !i_fifo_full;
        if (!discard_q && is_mwr && (!i_fifo_empty || i_cpl_busy))
            o_axis_master_trdy = 1'b0;
    end

    assign accept = i_axis_master_tvld && o_axis_master_trdy;

    //**********************************************************
    // read request into the completion queue
    assign o_req_push = accept && beat_ok && is_mrd;
    assign o_req_data = {hdr.req.tc, hdr.req.attr, hdr.req.req_id, hdr.req.tag,
                         hdr.req.addr[CPL_LO_W-1:0],
                         CPL_IDX_W'(hdr.req.addr[ADDR_WIDTH-1:0])};

    always_ff @(posedge clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rx_en       <= 1'b0;
            discard_q   <= 1'b0;
            o_mem_wr_en <= 1'b0;
        end
        else
        begin
            rx_en       <= 1'b1;
            o_mem_wr_en <= accept && beat_ok && is_mwr;
            // swallow the rest of any multi-beat packet
            if (accept)
                discard_q <= !i_axis_master_tlast;
        end
    end

    //**********************************************************
    // write payload, valid alongside o_mem_wr_en
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            o_mem_wr_addr <= hdr.req.addr[ADDR_WIDTH-1:0];
            o_mem_wr_data <= hdr.req.data;
            o_mem_wr_be   <= hdr.req.first_be;
        end
    end

endmodule

`default_nettype wire

// File: src.f
source/pcie_tlp_pkg.sv
source/dma_mem_pkg.sv
source/tlp_rx_parser.sv
source/bar_mem.sv
source/cpl_req_fifo.sv
source/cpl_tx_builder.sv
source/pcie_dma_top.sv
testbench/pcie_dma_asserts.sv
testbench/tb_pcie_dma.sv

// File: testbench/pcie_dma_asserts.sv
//**********************************************************
// Concurrent checks on the completion stream and the read
// request queue, bound into the DMA endpoint top level
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module pcie_dma_asserts #(
    parameter int DATA_W = pcie_tlp_pkg::TLP_DATA_W
)(
    input  wire              clk,
    input  wire              i_rst_n,
    input  wire              i_slave_tvld,
    input  wire              i_slave_trdy,
    input  wire [DATA_W-1:0] i_slave_tdata,
    input  wire              i_req_push,
    input  wire              i_fifo_full
);

    // stalled CplD beat holds valid and data
    stall_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_slave_tvld && !i_slave_trdy) |=> (i_slave_tvld && $stable(i_slave_tdata)))
        else $error("completion beat changed while the link stalled it");

    // parser never pushes into a full queue
    no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_req_push && i_fifo_full))
        else $error("read request pushed into a full queue");

    // nothing on the slave port right after reset
    idle_after_reset: assert property (@(posedge clk)
        $rose(i_rst_n) |-> !i_slave_tvld)
        else $error("completion valid high right after reset release");

endmodule

`default_nettype wire

// File: testbench/tb_pcie_dma.sv
//**********************************************************
// Testbench for the DMA endpoint target. Random MWR, MRD
// and unsupported TLPs are checked against a shadow memory
//**********************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_dma;

    import pcie_tlp_pkg::*;
    import dma_mem_pkg::*;

    localparam int ADDR_WIDTH   = DEF_ADDR_WIDTH;
    localparam int WORDS        = 2 ** ADDR_WIDTH;
    localparam int CLK_PERIOD   = 4;
    localparam int NUM_PAIRS    = 32;
    localparam int NUM_MIXED    = 300;
    localparam int NUM_BURSTS   = 12;
    localparam int BURST_LEN    = 6;
    localparam int NUM_UNSUP    = 24;
    localparam int NUM_TXN      = 2 * NUM_PAIRS + NUM_MIXED + NUM_BURSTS * (BURST_LEN + 1)
                                  + 2 * NUM_UNSUP + WORDS;
    // worst case cycles per transaction on a throttled link
    localparam int TXN_CYCLES   = 40;
    localparam int DRAIN_CYCLES = 400;
    localparam logic [7:0] BUS_NUM = 8'h3c;
    localparam logic [4:0] DEV_NUM = 5'h11;

    logic                  clk;
    logic                  i_rst_n;
    logic [7:0]            i_cfg_pbus_num;
    logic [4:0]            i_cfg_pbus_dev_num;
    logic                  i_axis_master_tvld;
    logic                  o_axis_master_trdy;
    logic [TLP_DATA_W-1:0] i_axis_master_tdata;
    logic [3:0]            i_axis_master_tkeep;
    logic                  i_axis_master_tlast;
    logic                  i_axis_slave_trdy;
    logic                  o_axis_slave_tvld;
    logic [TLP_DATA_W-1:0] o_axis_slave_tdata;
    logic                  o_axis_slave_tlast;

    logic [15:0]           lfsr_q;
    logic                  throttle;
    logic [MEM_WORD_W-1:0] shadow [WORDS];
    tlp_hdr_u              exp_q [$];
    logic                  in_discard;
    tlp_hdr_u              rx;
    tlp_hdr_u              exp_cpl;
    logic [ADDR_WIDTH-1:0] idx;

    pcie_dma_top #(
        .ADDR_WIDTH         (ADDR_WIDTH),
        .CPL_DEPTH          (DEF_CPL_DEPTH)
    ) uut (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_cfg_pbus_num     (i_cfg_pbus_num),
        .i_cfg_pbus_dev_num (i_cfg_pbus_dev_num),
        .i_axis_master_tvld (i_axis_master_tvld),
        .o_axis_master_trdy (o_axis_master_trdy),
        .i_axis_master_tdata(i_axis_master_tdata),
        .i_axis_master_tkeep(i_axis_master_tkeep),
        .i_axis_master_tlast(i_axis_master_tlast),
        .i_axis_slave_trdy  (i_axis_slave_trdy),
        .o_axis_slave_tvld  (o_axis_slave_tvld),
        .o_axis_slave_tdata (o_axis_slave_tdata),
        .o_axis_slave_tlast (o_axis_slave_tlast)
    );

    bind pcie_dma_top pcie_dma_asserts u_asserts (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_slave_tvld (o_axis_slave_tvld),
        .i_slave_trdy (i_axis_slave_trdy),
        .i_slave_tdata(o_axis_slave_tdata),
        .i_req_push   (req_push),
        .i_fifo_full  (fifo_full)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //**********************************************************
    // random source and error exit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        // taps 16 14 13 11
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_cpl(input tlp_hdr_u exp, input tlp_hdr_u act);
        if (act !== exp)
            stop_on_error($sformatf(
                "CHECK FAILED at %0t ns: o_axis_slave_tdata expected %h actual %h",
                $time, exp, act));
    endtask

    task automatic check_last(input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf(
                "CHECK FAILED at %0t ns: o_axis_slave_tlast expected %b actual %b",
                $time, exp, act));
    endtask

    task automatic check_trdy(input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf(
                "CHECK FAILED at %0t ns: o_axis_master_trdy expected %b actual %b",
                $time, exp, act));
    endtask

    //**********************************************************
    // reference model
    function automatic logic [31:0] merge_be(input logic [31:0] old, input logic [31:0] data,
                                             input logic [3:0] be);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                w[b*8 +: 8] = data[b*8 +: 8];
        return w;
    endfunction

    function automatic tlp_hdr_u expect_cpl(input tlp_hdr_u rq, input logic [31:0] word);
        tlp_hdr_u c;
        c                = '0;
        c.cpl.fmt_type   = FMT_TYPE_CPLD;
        c.cpl.length     = 10'd1;
        c.cpl.tc         = rq.req.tc;
        c.cpl.attr       = rq.req.attr;
        c.cpl.cpl_id     = {BUS_NUM, DEV_NUM, 3'b000};
        c.cpl.status     = CPL_STATUS_SC;
        c.cpl.byte_cnt   = 12'd4;
        c.cpl.req_id     = rq.req.req_id;
        c.cpl.tag        = rq.req.tag;
        c.cpl.lower_addr = {rq.req.addr[4:0], 2'b00};
        c.cpl.data       = word;
        return c;
    endfunction

    // transfers are sampled mid-cycle and complete on the next rising edge
    always @(negedge clk)
    begin
        if (!i_rst_n)
        begin
            in_discard = 1'b0;
            for (int i = 0; i < WORDS; i++)
                shadow[i] = '0;
            // no inbound beat is taken while in reset
            check_trdy(1'b0, o_axis_master_trdy);
        end
        else
        begin
            if (i_axis_master_tvld && o_axis_master_trdy)
            begin
                rx  = i_axis_master_tdata;
                idx = rx.req.addr[ADDR_WIDTH-1:0];
                if (!in_discard && i_axis_master_tlast && rx.req.length == 10'd1)
                begin
                    if (rx.req.fmt_type == FMT_TYPE_MWR32)
                        shadow[idx] = merge_be(shadow[idx], rx.req.data, rx.req.first_be);
                    else if (rx.req.fmt_type == FMT_TYPE_MRD32)
                        exp_q.push_back(expect_cpl(rx, shadow[idx]));
                end
                in_discard = !i_axis_master_tlast;
            end
            if (o_axis_slave_tvld && i_axis_slave_trdy)
            begin
                if (exp_q.size() == 0)
                    stop_on_error("completion beat arrived with no outstanding read request");
                else
                begin
                    exp_cpl = exp_q.pop_front();
                    check_cpl(exp_cpl, o_axis_slave_tdata);
                    check_last(1'b1, o_axis_slave_tlast);
                end
            end
        end
    end

    //**********************************************************
    // stimulus
    task automatic tick();
        @(posedge clk);
        #1;
        // link is mostly ready unless throttled
        if (throttle)
            i_axis_slave_trdy = (rand_bits(2) == 32'd3);
        else
            i_axis_slave_trdy = (rand_bits(2) != 32'd0);
    endtask

    task automatic send_beat(input logic [TLP_DATA_W-1:0] data, input logic last);
        logic taken;
        i_axis_master_tvld  = 1'b1;
        i_axis_master_tdata = data;
        i_axis_master_tlast = last;
        taken = 1'b0;
        while (!taken)
        begin
            @(negedge clk);
            taken = o_axis_master_trdy;
            tick();
        end
        i_axis_master_tvld = 1'b0;
    endtask

    function automatic tlp_hdr_u make_req(input logic [7:0] fmt, input logic [9:0] len,
                                          input logic [29:0] addr, input logic [3:0] be);
        tlp_hdr_u h;
        h              = '0;
        h.req.fmt_type = fmt;
        h.req.length   = len;
        h.req.addr     = addr;
        h.req.first_be = be;
        h.req.data     = rand_bits(32);
        h.req.tc       = 3'(rand_bits(3));
        h.req.attr     = 2'(rand_bits(2));
        h.req.req_id   = 16'(rand_bits(16));
        h.req.tag      = 8'(rand_bits(8));
        return h;
    endfunction

    task automatic send_req(input logic [7:0] fmt, input logic [9:0] len,
                            input logic [29:0] addr, input logic [3:0] be);
        send_beat(make_req(fmt, len, addr, be), 1'b1);
        repeat (rand_bits(2)) tick();
    endtask

    // header beat followed by one or two filler beats up to tlast
    task automatic send_multi(input logic [29:0] addr);
        int extra;
        extra = 1 + int'(rand_bits(1));
        send_beat(make_req(FMT_TYPE_MWR32, 10'd1, addr, 4'hf), 1'b0);
        for (int k = 0; k < extra; k++)
            send_beat({rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)},
                      k == extra - 1);
    endtask

    initial
    begin
        #(CLK_PERIOD * (16 + NUM_TXN * TXN_CYCLES));
        stop_on_error("watchdog timeout, test sequence did not finish in time");
    end

    initial
    begin
        logic [29:0] addr;
        lfsr_q              = 16'd26181;
        throttle            = 1'b0;
        i_rst_n             = 1'b0;
        i_cfg_pbus_num      = BUS_NUM;
        i_cfg_pbus_dev_num  = DEV_NUM;
        i_axis_master_tvld  = 1'b0;
        i_axis_master_tdata = '0;
        i_axis_master_tkeep = 4'hf;
        i_axis_master_tlast = 1'b0;
        i_axis_slave_trdy   = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        tick();

        // write then read back
        for (int n = 0; n < NUM_PAIRS; n++)
        begin
            addr = 30'(rand_bits(30));
            send_req(FMT_TYPE_MWR32, 10'd1, addr, 4'hf);
            send_req(FMT_TYPE_MRD32, 10'd1, addr, 4'hf);
        end

        // mixed traffic with partial byte enables
        for (int n = 0; n < NUM_MIXED; n++)
        begin
            addr = 30'(rand_bits(30));
            case (rand_bits(2))
                32'd0:   send_req(FMT_TYPE_MWR32, 10'd1, addr, 4'(rand_bits(4)));
                32'd1:   send_req(FMT_TYPE_MWR32, 10'd1, addr, 4'hf);
                default: send_req(FMT_TYPE_MRD32, 10'd1, addr, 4'hf);
            endcase
        end

        // read bursts against a slow link fill the queue
        throttle = 1'b1;
        for (int b = 0; b < NUM_BURSTS; b++)
        begin
            for (int k = 0; k < BURST_LEN; k++)
                send_beat(make_req(FMT_TYPE_MRD32, 10'd1, 30'(rand_bits(30)), 4'hf), 1'b1);
            send_req(FMT_TYPE_MWR32, 10'd1, 30'(rand_bits(30)), 4'(rand_bits(4)));
        end
        throttle = 1'b0;

        // unsupported packets each followed by a read of the same word
        for (int n = 0; n < NUM_UNSUP; n++)
        begin
            addr = 30'(rand_bits(30));
            case (rand_bits(2))
                32'd0:   send_multi(addr);
                32'd1:   send_req(FMT_TYPE_MWR32, 10'd2, addr, 4'hf);
                32'd2:   send_req(rand_bits(1) != 0 ? 8'h60 : 8'h04, 10'd1, addr, 4'hf);
                default: send_req(FMT_TYPE_MRD32, 10'd2, addr, 4'hf);
            endcase
            send_req(FMT_TYPE_MRD32, 10'd1, addr, 4'hf);
        end

        // sweep all words so untouched ones read back zero
        for (int i = 0; i < WORDS; i++)
            send_req(FMT_TYPE_MRD32, 10'd1, 30'(i), 4'hf);

        for (int c = 0; c < DRAIN_CYCLES && exp_q.size() != 0; c++)
            tick();
        if (exp_q.size() != 0)
            stop_on_error($sformatf("%0d expected completions never arrived", exp_q.size()));
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
